//--- oflow_tracker.f
source/oflow_pkg.sv
+incdir+include
source/oflow_hist_if.sv
source/oflow_frame_ingest.sv
source/oflow_history_buffer.sv
source/oflow_match_engine.sv
source/oflow_tracker.sv
testbench/oflow_tracker_tb.sv

//--- source/oflow_frame_ingest.sv
// frame intake
`timescale 1ns/1ps

module oflow_frame_ingest #(
	parameter int MAX_BBOXES = oflow_pkg::MAX_BBOXES_DEF
) (
	input  logic             clk,
	input  logic             reset_N,
	input  logic             bbox_valid_i,
	input  oflow_pkg::bbox_t bbox_i,
	input  logic             frame_end_i,
	output logic             ready_new_frame_o,
	hist_wr_if.ingest        wr
);
	import oflow_pkg::*;

	localparam int IDX_W = $clog2(MAX_BBOXES);
	localparam int CNT_W = $clog2(MAX_BBOXES + 1);

	ingest_state_e    state;
	logic [CNT_W-1:0] count;      // boxes taken this frame
	logic             busy_seen;  // buffer picked up the close
	logic             wait_over;
	logic             accept;
	logic             close_now;

	// ------------------------------
	// handshake with the buffer
	// ------------------------------
	// ready comes back the cycle busy falls, not a cycle later
	assign wait_over = (state == I_WAIT) && busy_seen && !wr.busy;
	assign ready_new_frame_o = (state == I_COLLECT) || wait_over;

	assign accept    = bbox_valid_i && ready_new_frame_o && (count < CNT_W'(MAX_BBOXES)); // extra strobes dropped
	assign close_now = frame_end_i && ready_new_frame_o;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state          <= I_COLLECT;
			count          <= '0;
			busy_seen      <= 1'b0;
			wr.wr_en       <= 1'b0;
			wr.frame_close <= 1'b0;
		end else begin
			wr.wr_en       <= accept;     // slot written next cycle
			wr.frame_close <= close_now;
			if (close_now) begin
				state     <= I_WAIT;
				count     <= '0;          // next frame starts at slot 0
				busy_seen <= 1'b0;
			end else begin
				if (accept)
					count <= count + 1'b1;
				if (wait_over) begin
					state     <= I_COLLECT;
					busy_seen <= 1'b0;
				end else if ((state == I_WAIT) && wr.busy) begin
					busy_seen <= 1'b1;
				end
			end
		end
	end

	// ------------------------------
	// write data and close count
	// ------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			wr.wr_index <= count[IDX_W-1:0];
			wr.wr_bbox  <= bbox_i;
		end
		if (close_now)
			wr.close_count <= count + CNT_W'(accept); // box on the closing cycle counts
	end

	// source must stop at capacity
	a_no_overrun: assert property (@(posedge clk) disable iff (!reset_N)
		(bbox_valid_i && ready_new_frame_o) |-> (count < CNT_W'(MAX_BBOXES)))
		else $error("box strobe with all %0d slots taken", MAX_BBOXES);

endmodule

//--- source/oflow_hist_if.sv
// history buffer paths
`timescale 1ns/1ps

// ingest to buffer
interface hist_wr_if #(
	parameter int MAX_BBOXES = oflow_pkg::MAX_BBOXES_DEF
);
	import oflow_pkg::*;

	localparam int IDX_W = $clog2(MAX_BBOXES);
	localparam int CNT_W = $clog2(MAX_BBOXES + 1);

	logic             wr_en;        // one slot per cycle
	logic [IDX_W-1:0] wr_index;
	bbox_t            wr_bbox;
	logic             frame_close;  // single pulse
	logic [CNT_W-1:0] close_count;  // boxes in the closed frame
	logic             busy;         // level, frame under match

	modport ingest (output wr_en, wr_index, wr_bbox, frame_close, close_count, input busy);
	modport buffer (input wr_en, wr_index, wr_bbox, frame_close, close_count, output busy);
endinterface

// match engine to buffer
interface hist_rd_if #(
	parameter int MAX_BBOXES = oflow_pkg::MAX_BBOXES_DEF
);
	import oflow_pkg::*;

	localparam int IDX_W = $clog2(MAX_BBOXES);
	localparam int CNT_W = $clog2(MAX_BBOXES + 1);

	logic             match_start;  // pulse
	logic [CNT_W-1:0] cur_count;
	logic [CNT_W-1:0] prev_count;
	bbox_t            prev_bbox;    // one cycle after prev_index
	logic [ID_W-1:0]  prev_id;
	bbox_t            cur_bbox;     // one cycle after cur_index
	logic [IDX_W-1:0] prev_index;
	logic [IDX_W-1:0] cur_index;
	logic             id_we;        // ID write into current bank
	logic [ID_W-1:0]  id_data;
	logic             swap;         // pulse, end of frame

	modport match (
		input  match_start, cur_count, prev_count, prev_bbox, prev_id, cur_bbox,
		output prev_index, cur_index, id_we, id_data, swap
	);
	modport buffer (
		output match_start, cur_count, prev_count, prev_bbox, prev_id, cur_bbox,
		input  prev_index, cur_index, id_we, id_data, swap
	);
endinterface

//--- source/oflow_history_buffer.sv
// two bank box history
`timescale 1ns/1ps

module oflow_history_buffer #(
	parameter int MAX_BBOXES = oflow_pkg::MAX_BBOXES_DEF
) (
	input  logic      clk,
	input  logic      reset_N,
	hist_wr_if.buffer wr,
	hist_rd_if.buffer rd
);
	import oflow_pkg::*;

	// ------------------------------
	// storage
	// ------------------------------
	bbox_t           bbox_mem [2][MAX_BBOXES];  // boxes per bank
	logic [ID_W-1:0] id_mem   [2][MAX_BBOXES];  // assigned IDs per bank

	logic bank_sel;   // bank of the frame being built
	logic prev_bank;

	assign prev_bank = ~bank_sel;

	// writes go to the current bank only
	always_ff @(posedge clk) begin
		if (wr.wr_en)
			bbox_mem[bank_sel][wr.wr_index] <= wr.wr_bbox;
		if (rd.id_we)
			id_mem[bank_sel][rd.cur_index] <= rd.id_data;   // match result
	end

	// registered reads, one cycle latency
	always_ff @(posedge clk) begin
		rd.prev_bbox <= bbox_mem[prev_bank][rd.prev_index];
		rd.prev_id   <= id_mem[prev_bank][rd.prev_index];
		rd.cur_bbox  <= bbox_mem[bank_sel][rd.cur_index];
	end

	// ------------------------------
	// frame control
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			bank_sel       <= 1'b0;
			wr.busy        <= 1'b0;
			rd.match_start <= 1'b0;
			rd.cur_count   <= '0;
			rd.prev_count  <= '0;     // nothing to match the first frame against
		end else begin
			rd.match_start <= wr.frame_close;
			if (wr.frame_close) begin
				rd.cur_count <= wr.close_count;
				wr.busy      <= 1'b1;   // held until swap
			end else if (rd.swap) begin
				bank_sel      <= ~bank_sel;          // current becomes previous
				rd.prev_count <= rd.cur_count;
				wr.busy       <= 1'b0;
			end
		end
	end

	// ingest must hold off while a frame is being matched
	a_no_write_busy: assert property (@(posedge clk) disable iff (!reset_N)
		wr.busy |-> !wr.wr_en)
		else $error("box write into history while match is running");

	// a new close may not arrive before the swap
	a_close_idle: assert property (@(posedge clk) disable iff (!reset_N)
		wr.frame_close |-> !wr.busy)
		else $error("frame close while previous frame still busy");

endmodule

//--- source/oflow_match_engine.sv
// box matcher and ID assignment
`timescale 1ns/1ps

module oflow_match_engine #(
	parameter int MAX_BBOXES = oflow_pkg::MAX_BBOXES_DEF
) (
	input  logic                            clk,
	input  logic                            reset_N,
	input  logic [oflow_pkg::WEIGHT_W-1:0]  pos_weight_i,
	input  logic [oflow_pkg::WEIGHT_W-1:0]  size_weight_i,
	input  logic [oflow_pkg::WEIGHT_W-1:0]  color_weight_i,
	input  logic [oflow_pkg::SCORE_W-1:0]   score_th_i,
	hist_rd_if.match                        rd,
	output logic                            valid_id_o,
	output logic [oflow_pkg::ID_W-1:0]      id_o,
	output logic [$clog2(MAX_BBOXES)-1:0]   id_index_o,
	output logic                            frame_done_o
);
	import oflow_pkg::*;

	localparam int IDX_W = $clog2(MAX_BBOXES);
	localparam int CNT_W = $clog2(MAX_BBOXES + 1);

	match_state_e     state;
	logic [IDX_W-1:0] scan_idx;     // previous box being read
	logic [IDX_W-1:0] cur_idx;      // new box being matched
	logic             rd_v1;        // read in flight, data next cycle
	logic             score_v;      // score_q holds a result
	logic [SCORE_W-1:0] score_q;
	logic [ID_W-1:0]    score_id_q;
	logic               best_v;
	logic [SCORE_W-1:0] best_score;
	logic [ID_W-1:0]    best_id;
	logic [ID_W-1:0]    fresh_id;   // wraps
	logic [COORD_W:0]   pos_sum;
	logic [COORD_W:0]   size_sum;
	logic [COORD_W-1:0] color_d;
	logic [SCORE_W-1:0] score_c;
	logic               take_best;
	logic               last_scan;
	logic               last_box;
	logic               matched;
	logic [ID_W-1:0]    emit_id;

	function automatic logic [COORD_W-1:0] absdiff(
		input logic [COORD_W-1:0] a,
		input logic [COORD_W-1:0] b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// ------------------------------
	// weighted score
	// ------------------------------
	assign pos_sum  = absdiff(rd.prev_bbox.x, rd.cur_bbox.x) + absdiff(rd.prev_bbox.y, rd.cur_bbox.y);
	assign size_sum = absdiff(rd.prev_bbox.w, rd.cur_bbox.w) + absdiff(rd.prev_bbox.h, rd.cur_bbox.h);
	assign color_d  = absdiff(rd.prev_bbox.color, rd.cur_bbox.color);
	assign score_c  = pos_weight_i * pos_sum + size_weight_i * size_sum
		+ color_weight_i * color_d;     // no overflow in 16 bits

	// strict less keeps the lowest index on ties
	assign take_best = score_v && (!best_v || (score_q < best_score));

	assign last_scan = (CNT_W'(scan_idx) + CNT_W'(1)) == rd.prev_count;
	assign last_box  = (CNT_W'(cur_idx) + CNT_W'(1)) == rd.cur_count;

	assign matched = best_v && (best_score <= score_th_i);
	assign emit_id = matched ? best_id : fresh_id;

	// buffer side
	assign rd.prev_index = scan_idx;
	assign rd.cur_index  = cur_idx;
	assign rd.id_we      = (state == M_EMIT);   // ID kept for the next frame
	assign rd.id_data    = emit_id;

	// ------------------------------
	// control FSM
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state        <= M_IDLE;
			scan_idx     <= '0;
			cur_idx      <= '0;
			rd_v1        <= 1'b0;
			score_v      <= 1'b0;
			best_v       <= 1'b0;
			fresh_id     <= '0;
			valid_id_o   <= 1'b0;
			frame_done_o <= 1'b0;
			rd.swap      <= 1'b0;
		end else begin
			rd_v1        <= 1'b0;
			score_v      <= rd_v1;
			valid_id_o   <= (state == M_EMIT);
			frame_done_o <= (state == M_DONE);
			rd.swap      <= (state == M_DONE);  // with frame_done_o
			if (take_best)
				best_v <= 1'b1;
			case (state)
				M_IDLE: begin
					if (rd.match_start) begin
						cur_idx  <= '0;
						scan_idx <= '0;
						state    <= (rd.cur_count == '0) ? M_DONE : M_SCAN; // empty frame
					end
				end
				M_SCAN: begin
					if (rd.prev_count == '0) begin
						state <= M_DRAIN;   // nothing to compare, fresh ID
					end else begin
						rd_v1    <= 1'b1;
						scan_idx <= scan_idx + 1'b1;
						if (last_scan)
							state <= M_DRAIN;
					end
				end
				M_DRAIN: begin
					// last score lands in best on the way out
					if (!rd_v1)
						state <= M_EMIT;
				end
				M_EMIT: begin
					best_v   <= 1'b0;
					scan_idx <= '0;
					if (!matched)
						fresh_id <= fresh_id + 1'b1;
					if (last_box) begin
						state <= M_DONE;
					end else begin
						cur_idx <= cur_idx + 1'b1;
						state   <= M_SCAN;
					end
				end
				M_DONE:  state <= M_IDLE;
				default: state <= M_IDLE;
			endcase
		end
	end

	// ------------------------------
	// score and result registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rd_v1) begin
			score_q    <= score_c;
			score_id_q <= rd.prev_id;
		end
		if (take_best) begin
			best_score <= score_q;
			best_id    <= score_id_q;
		end
		if (state == M_EMIT) begin
			id_o       <= emit_id;
			id_index_o <= cur_idx;
		end
	end

	// IDs only go to slots the buffer holds for this frame
	a_id_in_frame: assert property (@(posedge clk) disable iff (!reset_N)
		rd.id_we |-> (CNT_W'(rd.cur_index) < rd.cur_count))
		else $error("ID write to slot %0d beyond frame count", rd.cur_index);

endmodule

//--- source/oflow_pkg.sv
// tracker shared definitions
// widths, box type and FSM states

package oflow_pkg;

	// ------------------------------
	// field widths
	// ------------------------------
	localparam int COORD_W  = 8;    // x, y, w, h and color
	localparam int WEIGHT_W = 4;
	localparam int SCORE_W  = 16;   // worst case near 19k
	localparam int ID_W     = 8;

	// boxes per frame, top level default
	localparam int MAX_BBOXES_DEF = 16;

	// ------------------------------
	// box record
	// ------------------------------
	typedef struct packed {
		logic [COORD_W-1:0] x;      // center
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] w;      // size
		logic [COORD_W-1:0] h;
		logic [COORD_W-1:0] color;  // single color feature
	} bbox_t;

	// ------------------------------
	// FSM states
	// ------------------------------
	typedef enum logic {
		I_COLLECT,  // taking boxes
		I_WAIT      // frame closed, match running
	} ingest_state_e;

	typedef enum logic [2:0] {
		M_IDLE,     // wait for match_start
		M_SCAN,     // stream previous frame
		M_DRAIN,    // let the reads land
		M_EMIT,     // pick ID for one box
		M_DONE      // swap banks
	} match_state_e;

endpackage

//--- source/oflow_tracker.sv
// multi-object tracker top
`timescale 1ns/1ps

module oflow_tracker #(
	parameter int MAX_BBOXES = oflow_pkg::MAX_BBOXES_DEF
) (
	input  logic                           clk,
	input  logic                           reset_N,
	// box stream
	input  logic                           bbox_valid_i,
	input  logic [oflow_pkg::COORD_W-1:0]  bbox_x_i,
	input  logic [oflow_pkg::COORD_W-1:0]  bbox_y_i,
	input  logic [oflow_pkg::COORD_W-1:0]  bbox_w_i,
	input  logic [oflow_pkg::COORD_W-1:0]  bbox_h_i,
	input  logic [oflow_pkg::COORD_W-1:0]  bbox_color_i,
	input  logic                           frame_end_i,
	// score setup
	input  logic [oflow_pkg::WEIGHT_W-1:0] pos_weight_i,
	input  logic [oflow_pkg::WEIGHT_W-1:0] size_weight_i,
	input  logic [oflow_pkg::WEIGHT_W-1:0] color_weight_i,
	input  logic [oflow_pkg::SCORE_W-1:0]  score_th_i,
	// results
	output logic                           ready_new_frame_o,
	output logic                           valid_id_o,
	output logic [oflow_pkg::ID_W-1:0]     id_o,
	output logic [$clog2(MAX_BBOXES)-1:0]  id_index_o,
	output logic                           frame_done_o
);
	import oflow_pkg::*;

	bbox_t in_bbox;   // packed input box

	assign in_bbox = '{
		x:     bbox_x_i,
		y:     bbox_y_i,
		w:     bbox_w_i,
		h:     bbox_h_i,
		color: bbox_color_i
	};

	// ------------------------------
	// internal paths
	// ------------------------------
	hist_wr_if #(.MAX_BBOXES(MAX_BBOXES)) wr_if ();
	hist_rd_if #(.MAX_BBOXES(MAX_BBOXES)) rd_if ();

	oflow_frame_ingest #(.MAX_BBOXES(MAX_BBOXES)) ingest0 (
		.clk               (clk),
		.reset_N           (reset_N),
		.bbox_valid_i      (bbox_valid_i),
		.bbox_i            (in_bbox),
		.frame_end_i       (frame_end_i),
		.ready_new_frame_o (ready_new_frame_o),
		.wr                (wr_if.ingest)
	);

	oflow_history_buffer #(.MAX_BBOXES(MAX_BBOXES)) buffer0 (
		.clk     (clk),
		.reset_N (reset_N),
		.wr      (wr_if.buffer),
		.rd      (rd_if.buffer)
	);

	oflow_match_engine #(.MAX_BBOXES(MAX_BBOXES)) match0 (
		.clk            (clk),
		.reset_N        (reset_N),
		.pos_weight_i   (pos_weight_i),
		.size_weight_i  (size_weight_i),
		.color_weight_i (color_weight_i),
		.score_th_i     (score_th_i),
		.rd             (rd_if.match),
		.valid_id_o     (valid_id_o),
		.id_o           (id_o),
		.id_index_o     (id_index_o),
		.frame_done_o   (frame_done_o)
	);

endmodule

//--- include/oflow_tb_ref.svh
// tracker reference model
// expected IDs per frame
`ifndef OFLOW_TB_REF_SVH
`define OFLOW_TB_REF_SVH

bbox_t           new_boxes  [MAX_BBOXES];  // frame about to be sent
bbox_t           prev_boxes [MAX_BBOXES];  // last closed frame
logic [ID_W-1:0] prev_ids   [MAX_BBOXES];
int              prev_cnt      = 0;        // empty before the first frame
logic [ID_W-1:0] next_fresh_id = '0;       // wraps at ID_W bits

function automatic int abs_diff(input int a, input int b);
	return (a > b) ? a - b : b - a;
endfunction

// weighted similarity, lower is closer
function automatic int box_score(input bbox_t p, input bbox_t c,
	input int pw, input int sw, input int cw);
	return pw * (abs_diff(p.x, c.x) + abs_diff(p.y, c.y))
		+ sw * (abs_diff(p.w, c.w) + abs_diff(p.h, c.h))
		+ cw * abs_diff(p.color, c.color);
endfunction

// queue IDs for n new boxes, then the frame becomes the previous one
function automatic void predict_frame_ids(input int n, input int pw, input int sw,
	input int cw, input int th);
	logic [ID_W-1:0] ids [MAX_BBOXES];
	int best;
	int best_j;
	int s;
	for (int k = 0; k < n; k++) begin
		best_j = -1;
		best   = 0;
		for (int j = 0; j < prev_cnt; j++) begin
			s = box_score(prev_boxes[j], new_boxes[k], pw, sw, cw);
			if (best_j < 0 || s < best) begin   // strict, first index wins a tie
				best   = s;
				best_j = j;
			end
		end
		if (best_j >= 0 && best <= th) begin
			ids[k] = prev_ids[best_j];
		end else begin
			ids[k]        = next_fresh_id;       // no match, new track
			next_fresh_id = next_fresh_id + 1'b1;
		end
		exp_ids.push_back(ids[k]);
		exp_index.push_back(k);
	end
	for (int k = 0; k < n; k++) begin
		prev_boxes[k] = new_boxes[k];
		prev_ids[k]   = ids[k];
	end
	prev_cnt = n;
endfunction

`endif

//--- testbench/oflow_tracker_tb.sv
// tracker testbench
`timescale 1ns/1ps

module oflow_tracker_tb;
	import oflow_pkg::*;

	localparam int MAX_BBOXES  = MAX_BBOXES_DEF;
	localparam int READY_LIMIT = 200;    // cycles
	localparam int DONE_LIMIT  = 2000;   // full frame needs about 350

	logic                          clk;
	logic                          reset_N;
	logic                          bbox_valid_i;
	logic [COORD_W-1:0]            bbox_x_i, bbox_y_i, bbox_w_i, bbox_h_i, bbox_color_i;
	logic                          frame_end_i;
	logic [WEIGHT_W-1:0]           pos_weight_i, size_weight_i, color_weight_i;
	logic [SCORE_W-1:0]            score_th_i;
	logic                          ready_new_frame_o;
	logic                          valid_id_o;
	logic [ID_W-1:0]               id_o;
	logic [$clog2(MAX_BBOXES)-1:0] id_index_o;
	logic                          frame_done_o;

	logic [ID_W-1:0] exp_ids   [$];  // filled by the reference model
	int              exp_index [$];
	int              errors    = 0;
	int              checks    = 0;
	integer          seed      = 69926;
	string           test_name = "reset";

	`include "oflow_tb_ref.svh"

	oflow_tracker #(.MAX_BBOXES(MAX_BBOXES)) dut0 (.*);

	always #50 clk = ~clk;

	// ------------------------------
	// compare process
	// ------------------------------
	always @(negedge clk) begin
		if (reset_N && valid_id_o) begin
			checks++;
			assert (exp_ids.size() > 0) else begin
				$display("ID output in %s when no ID was due", test_name);
				errors++;
			end
			if (exp_ids.size() > 0) begin
				assert (id_index_o == exp_index[0]) else begin
					$display("CHECK FAILED %s index: expected %0d, actual %0d",
						test_name, exp_index[0], id_index_o);
					errors++;
				end
				assert (id_o == exp_ids[0]) else begin
					$display("CHECK FAILED %s id: expected %0d, actual %0d",
						test_name, exp_ids[0], id_o);
					errors++;
				end
				void'(exp_ids.pop_front());
				void'(exp_index.pop_front());
			end
		end
	end

	task automatic finish_run();
		$display("errors: %0d, IDs checked: %0d", errors, checks);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ready_new_frame_o && cycles < READY_LIMIT);
		if (!ready_new_frame_o) begin
			$display("timeout in %s, ready_new_frame_o never came back", test_name);
			errors++;
			finish_run();
		end
	endtask

	// ready must stay low the whole time
	task automatic wait_frame_done();
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < DONE_LIMIT) begin
			@(negedge clk);
			cycles++;
			assert (!ready_new_frame_o) else begin
				$display("ready_new_frame_o high before frame_done_o in %s", test_name);
				errors++;
			end
			seen = frame_done_o;
		end
		if (!seen) begin
			$display("timeout in %s, frame_done_o never came", test_name);
			errors++;
			finish_run();
		end
	endtask

	task automatic set_weights(input int pw, input int sw, input int cw, input int th);
		@(posedge clk);
		pos_weight_i   <= WEIGHT_W'(pw);
		size_weight_i  <= WEIGHT_W'(sw);
		color_weight_i <= WEIGHT_W'(cw);
		score_th_i     <= SCORE_W'(th);
	endtask

	function automatic void set_box(input int k, input int x, input int y, input int w,
		input int h, input int c);
		new_boxes[k] = '{x: x[7:0], y: y[7:0], w: w[7:0], h: h[7:0], color: c[7:0]};
	endfunction

	// small step around v, wraps in 8 bits
	function automatic logic [COORD_W-1:0] nudge(input logic [COORD_W-1:0] v);
		return v + COORD_W'($random(seed) % 8);
	endfunction

	// half the boxes follow the last frame, the rest land anywhere
	function automatic void random_frame();
		for (int k = 0; k < MAX_BBOXES; k++) begin
			if (k < prev_cnt && ($random(seed) & 1))
				new_boxes[k] = '{x: nudge(prev_boxes[k].x), y: nudge(prev_boxes[k].y),
					w: nudge(prev_boxes[k].w), h: nudge(prev_boxes[k].h),
					color: nudge(prev_boxes[k].color)};
			else
				new_boxes[k] = '{x: 8'($random(seed)), y: 8'($random(seed)),
					w: 8'($random(seed)), h: 8'($random(seed)), color: 8'($random(seed))};
		end
	endfunction

	task automatic send_frame(input int n);
		int k;
		wait_ready();
		predict_frame_ids(n, pos_weight_i, size_weight_i, color_weight_i, score_th_i);
		for (k = 0; k < n; k++) begin
			@(posedge clk);
			bbox_valid_i <= 1'b1;
			bbox_x_i     <= new_boxes[k].x;
			bbox_y_i     <= new_boxes[k].y;
			bbox_w_i     <= new_boxes[k].w;
			bbox_h_i     <= new_boxes[k].h;
			bbox_color_i <= new_boxes[k].color;
		end
		@(posedge clk);
		bbox_valid_i <= 1'b0;
		frame_end_i  <= 1'b1;
		@(posedge clk);
		frame_end_i  <= 1'b0;
		wait_frame_done();
		assert (exp_ids.size() == 0) else begin
			$display("%s ended with %0d IDs never sent", test_name, exp_ids.size());
			errors++;
			exp_ids.delete();
			exp_index.delete();
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		clk            = 1'b0;
		reset_N        = 1'b0;
		bbox_valid_i   = 1'b0;
		bbox_x_i       = '0;
		bbox_y_i       = '0;
		bbox_w_i       = '0;
		bbox_h_i       = '0;
		bbox_color_i   = '0;
		frame_end_i    = 1'b0;
		pos_weight_i   = '0;
		size_weight_i  = '0;
		color_weight_i = '0;
		score_th_i     = '0;
		repeat (4) @(posedge clk);
		reset_N <= 1'b1;
		@(negedge clk);
		assert (ready_new_frame_o && !valid_id_o && !frame_done_o) else begin
			$display("outputs wrong right after reset");
			errors++;
		end
		set_weights(2, 1, 1, 40);

		test_name = "first_frame";       // all fresh, 0 to 4
		set_box(0, 20, 20, 10, 10, 50);
		set_box(1, 60, 20, 10, 10, 50);  // twin of box 0, 40 apart
		set_box(2, 100, 40, 8, 8, 120);
		set_box(3, 140, 80, 16, 16, 160);
		set_box(4, 200, 200, 20, 20, 200);
		send_frame(5);

		test_name = "same_frame";
		send_frame(5);

		test_name = "shifted_frame";
		set_box(0, 40, 20, 10, 10, 50);    // tie at threshold, lower index
		set_box(1, 23, 22, 10, 10, 50);    // near box 0
		set_box(2, 100, 44, 8, 8, 120);
		set_box(3, 250, 5, 30, 30, 10);    // far
		set_box(4, 5, 250, 3, 3, 240);     // far
		set_box(5, 140, 80, 16, 16, 160);
		send_frame(6);

		test_name = "empty_frame";
		send_frame(0);
		test_name = "after_empty";
		set_box(0, 40, 20, 10, 10, 50);
		set_box(1, 100, 44, 8, 8, 120);
		set_box(2, 140, 80, 16, 16, 160);
		send_frame(3);

		for (int f = 0; f < 10; f++) begin
			test_name = $sformatf("random_frame_%0d", f);
			set_weights($random(seed) & 15, $random(seed) & 15, $random(seed) & 15,
				$random(seed) & 16'h03ff);
			random_frame();
			send_frame(MAX_BBOXES);
		end
		finish_run();
	end

endmodule
